// ==== source/ntm_defines.svh ====
// Matrix sizes and fixed-point format defines
`ifndef NTM_DEFINES_SVH
`define NTM_DEFINES_SVH

////////////////////
// Matrix geometry
////////////////////

// Rows of the memory, also weighting length
`define NTM_SIZE_N 4
// Words per row, also erase and add length
`define NTM_SIZE_W 4

////////////////////
// Fixed point
////////////////////

`define NTM_DATA_WIDTH 16
// Unsigned fraction, room for exactly 1.0
`define NTM_WEIGHT_WIDTH 9
`define NTM_FRAC_BITS 8
`define NTM_ONE 256

`endif

// ==== source/ntm_pkg.sv ====
// Word, weight, address and operation types plus the fixed-point multiply
`include "ntm_defines.svh"

package ntm_pkg;

  // Signed memory word
  typedef logic signed [`NTM_DATA_WIDTH-1:0] word_t;
  // Unsigned fraction, 1.0 = NTM_ONE
  typedef logic [`NTM_WEIGHT_WIDTH-1:0] weight_t;

  typedef logic [$clog2(`NTM_SIZE_N)-1:0] row_addr_t;
  typedef logic [$clog2(`NTM_SIZE_W)-1:0] col_addr_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_t;

  // Weight times word, floor of full product over 2^FRAC_BITS
  // Result wraps to the word width
  function automatic word_t fx_mul(input weight_t w, input word_t d);
    logic signed [`NTM_DATA_WIDTH+`NTM_WEIGHT_WIDTH:0] prod;
    // Zero extend so the weight stays positive
    prod = $signed({1'b0, w}) * d;
    return prod[`NTM_FRAC_BITS +: `NTM_DATA_WIDTH];
  endfunction

endpackage

// ==== source/ntm_vector_buffer.sv ====
// Strobe-loaded vector register with a wrapping fill index
`timescale 1ns/1ps
`include "ntm_defines.svh"

module ntm_vector_buffer
  import ntm_pkg::*;
#(
  parameter type T = word_t,
  parameter int DEPTH = `NTM_SIZE_N
) (
  input  logic CLK,
  input  logic RST,
  input  logic clear,
  input  logic load,
  input  T     data,
  output T     vector [DEPTH]
);

  localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [IW-1:0] LAST = IW'(DEPTH - 1);

  // Next slot to fill
  logic [IW-1:0] idx;

  ////////////////////
  // Fill index
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      idx <= '0;
    end else if (clear) begin
      idx <= '0;
    end else if (load) begin
      // Wrap after the last slot
      idx <= (idx == LAST) ? '0 : idx + 1'b1;
    end
  end

  // Slot storage
  always_ff @(posedge CLK) begin
    if (load) begin
      vector[idx] <= data;
    end
  end

  // Host never streams data in the START cycle
  a_no_load_on_clear : assert property (@(posedge CLK) disable iff (RST)
    !(load && clear));

endmodule

// ==== source/ntm_memory.sv ====
// N x W memory matrix, two registered read ports and one write port
`timescale 1ns/1ps
`include "ntm_defines.svh"

module ntm_memory
  import ntm_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  // Port A, read head
  input  row_addr_t rd_a_row,
  input  col_addr_t rd_a_col,
  output word_t     rd_a_data,
  // Port B, write head
  input  row_addr_t rd_b_row,
  input  col_addr_t rd_b_col,
  output word_t     rd_b_data,
  // Write port
  input  logic      wr_en,
  input  row_addr_t wr_row,
  input  col_addr_t wr_col,
  input  word_t     wr_data
);

  word_t mem [`NTM_SIZE_N][`NTM_SIZE_W];

  ////////////////////
  // Write and clear
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      // Whole matrix back to zero
      for (int j = 0; j < `NTM_SIZE_N; j++) begin
        for (int k = 0; k < `NTM_SIZE_W; k++) begin
          mem[j][k] <= '0;
        end
      end
    end else if (wr_en) begin
      mem[wr_row][wr_col] <= wr_data;
    end
  end

  // Reads see the value before a same-cycle write
  always_ff @(posedge CLK) begin
    rd_a_data <= mem[rd_a_row][rd_a_col];
    rd_b_data <= mem[rd_b_row][rd_b_col];
  end

endmodule

// ==== source/ntm_reading.sv ====
// Read head, weighted sum of each memory column
`timescale 1ns/1ps
`include "ntm_defines.svh"

module ntm_reading
  import ntm_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      start,
  input  weight_t   weights [`NTM_SIZE_N],
  output row_addr_t rd_row,
  output col_addr_t rd_col,
  input  word_t     rd_data,
  output logic      r_valid,
  output word_t     r_data,
  output logic      done
);

  localparam row_addr_t ROW_LAST = row_addr_t'(`NTM_SIZE_N - 1);
  localparam col_addr_t COL_LAST = col_addr_t'(`NTM_SIZE_W - 1);

  // Issue side
  logic      active;
  row_addr_t row0;
  col_addr_t col0;
  logic      col_end;
  logic      at_last;
  // Return side, one cycle behind
  logic      v1;
  logic      end1;
  logic      last1;
  row_addr_t row1;
  word_t     sum;

  assign rd_row  = row0;
  assign rd_col  = col0;
  assign col_end = (row0 == ROW_LAST);
  assign at_last = col_end && (col0 == COL_LAST);

  // Row 0 restarts the sum, so the next column overlaps freely
  assign sum = ((row1 == '0) ? word_t'(0) : r_data) + fx_mul(weights[row1], rd_data);

  ////////////////////
  // Address walk
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active  <= 1'b0;
      row0    <= '0;
      col0    <= '0;
      v1      <= 1'b0;
      end1    <= 1'b0;
      last1   <= 1'b0;
      r_valid <= 1'b0;
      done    <= 1'b0;
    end else begin
      if (start) begin
        active <= 1'b1;
        row0   <= '0;
        col0   <= '0;
      end else if (active) begin
        // Rows inner, columns outer
        if (col_end) begin
          row0 <= '0;
          col0 <= col0 + 1'b1;
        end else begin
          row0 <= row0 + 1'b1;
        end
        if (at_last) begin
          active <= 1'b0;
        end
      end
      v1      <= active;
      end1    <= active && col_end;
      last1   <= active && at_last;
      // Column sum lands with its N-th word
      r_valid <= v1 && end1;
      done    <= v1 && last1;
    end
  end

  // Accumulator doubles as the output word
  always_ff @(posedge CLK) begin
    row1 <= row0;
    if (v1) begin
      r_data <= sum;
    end
  end

  a_start_idle : assert property (@(posedge CLK) disable iff (RST)
    start |-> !active && !v1);

endmodule

// ==== source/ntm_write_head.sv ====
// Write head, erase then add over every cell as a three-stage pipeline
`timescale 1ns/1ps
`include "ntm_defines.svh"

module ntm_write_head
  import ntm_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      start,
  input  weight_t   weights [`NTM_SIZE_N],
  input  weight_t   erase [`NTM_SIZE_W],
  input  word_t     add [`NTM_SIZE_W],
  output row_addr_t rd_row,
  output col_addr_t rd_col,
  input  word_t     rd_data,
  output logic      wr_en,
  output row_addr_t wr_row,
  output col_addr_t wr_col,
  output word_t     wr_data,
  output logic      done
);

  localparam row_addr_t ROW_LAST = row_addr_t'(`NTM_SIZE_N - 1);
  localparam col_addr_t COL_LAST = col_addr_t'(`NTM_SIZE_W - 1);
  localparam word_t     ONE_W    = word_t'(`NTM_ONE);

  // Stage 0, address issue
  logic      active;
  row_addr_t row0;
  col_addr_t col0;
  logic      at_last;
  // Stage 1, word back from memory
  logic      v1;
  logic      last1;
  row_addr_t row1;
  col_addr_t col1;
  // Stage 2, erased word held for the add
  logic      v2;
  logic      last2;
  row_addr_t row2;
  col_addr_t col2;
  word_t     erased_q;
  // Erase arithmetic
  word_t     we_prod;
  weight_t   keep;
  word_t     erased;

  assign rd_row  = row0;
  assign rd_col  = col0;
  assign at_last = (row0 == ROW_LAST) && (col0 == COL_LAST);

  ////////////////////
  // Erase stage
  ////////////////////

  always_comb begin
    we_prod = fx_mul(weights[row1], word_t'(erase[col1]));
    // Kept fraction 1 - w*e
    keep    = weight_t'(ONE_W - we_prod);
    erased  = fx_mul(keep, rd_data);
  end

  // Cell sweep, columns inner
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active <= 1'b0;
      row0   <= '0;
      col0   <= '0;
      v1     <= 1'b0;
      last1  <= 1'b0;
      v2     <= 1'b0;
      last2  <= 1'b0;
    end else begin
      if (start) begin
        active <= 1'b1;
        row0   <= '0;
        col0   <= '0;
      end else if (active) begin
        if (col0 == COL_LAST) begin
          col0 <= '0;
          row0 <= row0 + 1'b1;
        end else begin
          col0 <= col0 + 1'b1;
        end
        if (at_last) begin
          active <= 1'b0;
        end
      end
      v1    <= active;
      last1 <= active && at_last;
      v2    <= v1;
      last2 <= last1;
    end
  end

  // Address and data follow the valid bits
  always_ff @(posedge CLK) begin
    row1     <= row0;
    col1     <= col0;
    row2     <= row1;
    col2     <= col1;
    erased_q <= erased;
  end

  ////////////////////
  // Add stage
  ////////////////////

  // Write-back two cycles after the read
  assign wr_en   = v2;
  assign wr_row  = row2;
  assign wr_col  = col2;
  assign wr_data = erased_q + fx_mul(weights[row2], add[col2]);
  assign done    = last2;

endmodule

// ==== source/ntm_sequencer.sv ====
// Top FSM, launches a head per operation and pulses ready on its done
`timescale 1ns/1ps

module ntm_sequencer
  import ntm_pkg::*;
(
  input  logic CLK,
  input  logic RST,
  input  logic start,
  input  op_t  op,
  input  logic read_done,
  input  logic write_done,
  output logic read_start,
  output logic write_start,
  output logic ready
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ_HEADS,
    S_WRITE_HEADS
  } state_t;

  state_t state;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= S_IDLE;
      read_start  <= 1'b0;
      write_start <= 1'b0;
      ready       <= 1'b0;
    end else begin
      // Single-cycle strobes by default
      read_start  <= 1'b0;
      write_start <= 1'b0;
      ready       <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            if (op == OP_WRITE) begin
              state       <= S_WRITE_HEADS;
              write_start <= 1'b1;
            end else begin
              state      <= S_READ_HEADS;
              read_start <= 1'b1;
            end
          end
        end
        S_READ_HEADS: begin
          if (read_done) begin
            state <= S_IDLE;
            ready <= 1'b1;
          end
        end
        S_WRITE_HEADS: begin
          if (write_done) begin
            state <= S_IDLE;
            ready <= 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // No back-pressure, host waits for READY
  a_start_in_idle : assert property (@(posedge CLK) disable iff (RST)
    start |-> state == S_IDLE);

endmodule

// ==== source/ntm_top.sv ====
// Top level, vector buffers, memory, read and write heads and sequencer
`timescale 1ns/1ps
`include "ntm_defines.svh"

module ntm_top (
  input  logic            CLK,
  input  logic            RST,
  input  logic            START,
  input  ntm_pkg::op_t    OP,
  input  logic            W_IN_ENABLE,
  input  ntm_pkg::weight_t W_IN,
  input  logic            E_IN_ENABLE,
  input  ntm_pkg::weight_t E_IN,
  input  logic            A_IN_ENABLE,
  input  ntm_pkg::word_t  A_IN,
  output logic            R_OUT_ENABLE,
  output ntm_pkg::word_t  R_OUT,
  output logic            READY
);

  // Loaded vectors
  ntm_pkg::weight_t weights [`NTM_SIZE_N];
  ntm_pkg::weight_t erase [`NTM_SIZE_W];
  ntm_pkg::word_t   add [`NTM_SIZE_W];

  // Memory ports
  ntm_pkg::row_addr_t rd_a_row;
  ntm_pkg::col_addr_t rd_a_col;
  ntm_pkg::word_t     rd_a_data;
  ntm_pkg::row_addr_t rd_b_row;
  ntm_pkg::col_addr_t rd_b_col;
  ntm_pkg::word_t     rd_b_data;
  logic               wr_en;
  ntm_pkg::row_addr_t wr_row;
  ntm_pkg::col_addr_t wr_col;
  ntm_pkg::word_t     wr_data;

  // Head control
  logic read_start;
  logic read_done;
  logic write_start;
  logic write_done;

  ////////////////////
  // Input vectors
  ////////////////////

  // START rewinds every fill index
  ntm_vector_buffer #(.T(ntm_pkg::weight_t), .DEPTH(`NTM_SIZE_N)) u_w_buf (
    .CLK(CLK), .RST(RST), .clear(START), .load(W_IN_ENABLE), .data(W_IN), .vector(weights)
  );
  ntm_vector_buffer #(.T(ntm_pkg::weight_t), .DEPTH(`NTM_SIZE_W)) u_e_buf (
    .CLK(CLK), .RST(RST), .clear(START), .load(E_IN_ENABLE), .data(E_IN), .vector(erase)
  );
  ntm_vector_buffer #(.T(ntm_pkg::word_t), .DEPTH(`NTM_SIZE_W)) u_a_buf (
    .CLK(CLK), .RST(RST), .clear(START), .load(A_IN_ENABLE), .data(A_IN), .vector(add)
  );

  ////////////////////
  // Memory and heads
  ////////////////////

  ntm_memory u_memory (
    .CLK(CLK), .RST(RST),
    .rd_a_row(rd_a_row), .rd_a_col(rd_a_col), .rd_a_data(rd_a_data),
    .rd_b_row(rd_b_row), .rd_b_col(rd_b_col), .rd_b_data(rd_b_data),
    .wr_en(wr_en), .wr_row(wr_row), .wr_col(wr_col), .wr_data(wr_data)
  );

  // Read head on port A
  ntm_reading u_reading (
    .CLK(CLK), .RST(RST), .start(read_start), .weights(weights),
    .rd_row(rd_a_row), .rd_col(rd_a_col), .rd_data(rd_a_data),
    .r_valid(R_OUT_ENABLE), .r_data(R_OUT), .done(read_done)
  );

  // Write head on port B, sole owner of the write port
  ntm_write_head u_write_head (
    .CLK(CLK), .RST(RST), .start(write_start),
    .weights(weights), .erase(erase), .add(add),
    .rd_row(rd_b_row), .rd_col(rd_b_col), .rd_data(rd_b_data),
    .wr_en(wr_en), .wr_row(wr_row), .wr_col(wr_col), .wr_data(wr_data),
    .done(write_done)
  );

  ntm_sequencer u_sequencer (
    .CLK(CLK), .RST(RST), .start(START), .op(OP),
    .read_done(read_done), .write_done(write_done),
    .read_start(read_start), .write_start(write_start), .ready(READY)
  );

endmodule

// ==== tests/ntm_top_tb.sv ====
// Table-driven testbench for the NTM memory top level, with checks and watchdog
`timescale 1ns/1ps
`include "ntm_defines.svh"

module ntm_top_tb
  import ntm_pkg::*;
();

  localparam int N          = `NTM_SIZE_N;
  localparam int W          = `NTM_SIZE_W;
  localparam int CLK_PERIOD = 4;
  localparam int NUM_ROWS   = 12;
  localparam int LOAD_LEN   = (N > W) ? N : W;

  // Column layout of one table row
  localparam int C_OP = 0;
  localparam int C_W  = 1;
  localparam int C_E  = C_W + N;
  localparam int C_A  = C_E + W;
  localparam int C_R  = C_A + W;
  localparam int COLS = C_R + W;

  // Per-operation wait and total run limit in cycles
  localparam int OP_CYCLES       = N * W + 20;
  localparam int WATCHDOG_CYCLES = 2 * NUM_ROWS * OP_CYCLES;

  ////////////////////
  // Stimulus table
  ////////////////////

  // op | w(0..3) | e(0..3) | a(0..3) | expected r(0..3)
  // Expected words hand-computed with floor products
  localparam int TAB [NUM_ROWS][COLS] = '{
    '{OP_READ,  256, 256, 256, 256,   0,   0,   0,   0,     0,    0,    0,   0,
      0, 0, 0, 0},
    '{OP_WRITE,   0, 256,   0,   0,   0,   0,   0,   0,   100, -200,    7,  -1,
      0, 0, 0, 0},
    '{OP_READ,    0, 256,   0,   0,   0,   0,   0,   0,     0,    0,    0,   0,
      100, -200, 7, -1},
    '{OP_READ,  256,   0,   0,   0,   0,   0,   0,   0,     0,    0,    0,   0,
      0, 0, 0, 0},
    // Full erase then new add on row 1
    '{OP_WRITE,   0, 256,   0,   0, 256, 256, 256, 256,  -300,   50, 1000,  -5,
      0, 0, 0, 0},
    '{OP_READ,    0, 256,   0,   0,   0,   0,   0,   0,     0,    0,    0,   0,
      -300, 50, 1000, -5},
    '{OP_WRITE,   0,   0, 256,   0,   0,   0,   0,   0,     3,   -3,  301,  -7,
      0, 0, 0, 0},
    // Half of rows 1 and 2
    // Odd negatives round down
    '{OP_READ,    0, 128, 128,   0,   0,   0,   0,   0,     0,    0,    0,   0,
      -149, 23, 650, -7},
    // 0.25 into row 0, 0.75 into row 3
    '{OP_WRITE,  64,   0,   0, 192,   0,   0,   0,   0,   100, -100,    7,  -7,
      0, 0, 0, 0},
    '{OP_READ,  256,   0,   0,   0,   0,   0,   0,   0,     0,    0,    0,   0,
      25, -25, 1, -2},
    '{OP_READ,    0,   0,   0, 256,   0,   0,   0,   0,     0,    0,    0,   0,
      75, -75, 5, -6},
    // Row 1 untouched by the spread write
    '{OP_READ,    0, 256,   0,   0,   0,   0,   0,   0,     0,    0,    0,   0,
      -300, 50, 1000, -5}
  };

  string row_name [NUM_ROWS] = '{
    "reset_read", "write_row1", "read_row1", "read_row0", "replace_row1",
    "read_new_row1", "write_row2", "read_half", "write_spread",
    "read_row0_scaled", "read_row3_scaled", "read_row1_kept"
  };

  // DUT ports
  logic    CLK;
  logic    RST;
  logic    START;
  op_t     OP;
  logic    W_IN_ENABLE;
  weight_t W_IN;
  logic    E_IN_ENABLE;
  weight_t E_IN;
  logic    A_IN_ENABLE;
  word_t   A_IN;
  logic    R_OUT_ENABLE;
  word_t   R_OUT;
  logic    READY;

  int value_errors    = 0;
  int protocol_errors = 0;
  int checked         = 0;

  ntm_top UUT (
    .CLK(CLK), .RST(RST), .START(START), .OP(OP),
    .W_IN_ENABLE(W_IN_ENABLE), .W_IN(W_IN),
    .E_IN_ENABLE(E_IN_ENABLE), .E_IN(E_IN),
    .A_IN_ENABLE(A_IN_ENABLE), .A_IN(A_IN),
    .R_OUT_ENABLE(R_OUT_ENABLE), .R_OUT(R_OUT), .READY(READY)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  ////////////////////
  // Driver tasks
  ////////////////////

  // Stream one row's vectors and pulse START
  task automatic load_and_start(input int r);
    for (int i = 0; i < LOAD_LEN; i++) begin
      @(posedge CLK);
      W_IN_ENABLE <= (i < N);
      E_IN_ENABLE <= (i < W);
      A_IN_ENABLE <= (i < W);
      if (i < N) begin
        W_IN <= weight_t'(TAB[r][C_W + i]);
      end
      if (i < W) begin
        E_IN <= weight_t'(TAB[r][C_E + i]);
        A_IN <= word_t'(TAB[r][C_A + i]);
      end
    end
    // Strobes drop in the START cycle
    @(posedge CLK);
    W_IN_ENABLE <= 1'b0;
    E_IN_ENABLE <= 1'b0;
    A_IN_ENABLE <= 1'b0;
    START       <= 1'b1;
    OP          <= op_t'(TAB[r][C_OP]);
    @(posedge CLK);
    START <= 1'b0;
  endtask

  // Gather R_OUT words until READY
  task automatic collect_results(input int r);
    int    pulses;
    int    cycles;
    int    exp_pulses;
    bit    seen_ready;
    word_t expected;
    pulses     = 0;
    cycles     = 0;
    seen_ready = 1'b0;
    exp_pulses = (TAB[r][C_OP] == OP_READ) ? W : 0;
    while (!seen_ready && cycles < OP_CYCLES) begin
      @(negedge CLK);
      cycles++;
      // Last word lands before READY
      assert (!(R_OUT_ENABLE && READY)) else begin
        protocol_errors++;
        $display("%s: R_OUT_ENABLE and READY were high in the same cycle", row_name[r]);
      end
      if (R_OUT_ENABLE) begin
        if (pulses < W) begin
          expected = word_t'(TAB[r][C_R + pulses]);
          checked++;
          assert (R_OUT == expected) else begin
            value_errors++;
            $display("Error: %s r(%0d) expected %0d actual %0d",
                     row_name[r], pulses, expected, R_OUT);
          end
        end
        pulses++;
      end
      seen_ready = READY;
    end
    assert (seen_ready) else begin
      protocol_errors++;
      $display("%s: READY never came within %0d cycles", row_name[r], OP_CYCLES);
    end
    assert (pulses == exp_pulses) else begin
      protocol_errors++;
      $display("%s: saw %0d R_OUT_ENABLE pulses where %0d were due",
               row_name[r], pulses, exp_pulses);
    end
    // Exactly one READY cycle and no word after it
    @(negedge CLK);
    assert (!READY) else begin
      protocol_errors++;
      $display("%s: READY stayed high longer than one cycle", row_name[r]);
    end
    assert (!R_OUT_ENABLE) else begin
      protocol_errors++;
      $display("%s: R_OUT_ENABLE pulsed after READY", row_name[r]);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    RST         = 1'b1;
    START       = 1'b0;
    OP          = OP_READ;
    W_IN_ENABLE = 1'b0;
    W_IN        = '0;
    E_IN_ENABLE = 1'b0;
    E_IN        = '0;
    A_IN_ENABLE = 1'b0;
    A_IN        = '0;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;
    @(negedge CLK);
    assert (!READY && !R_OUT_ENABLE) else begin
      protocol_errors++;
      $display("READY or R_OUT_ENABLE was high right after reset");
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      load_and_start(r);
      collect_results(r);
    end
    $display("Errors: %0d value, %0d protocol, %0d outputs checked",
             value_errors, protocol_errors, checked);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Twice the worst case of all rows
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Watchdog: run still going after %0d cycles, stopped", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+source
source/ntm_pkg.sv
source/ntm_vector_buffer.sv
source/ntm_memory.sv
source/ntm_reading.sv
source/ntm_write_head.sv
source/ntm_sequencer.sv
source/ntm_top.sv
tests/ntm_top_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module ntm_top_tb \
  -Mdir obj_dir -o ntm_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/ntm_sim > sim.log 2>&1
grep -q "^Result: PASSED$" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
